//--- rv_core.f
rv_pkg.sv
rv_mux_key.sv
rv_ifu.sv
rv_idu.sv
rv_regfile.sv
rv_exu.sv
rv_core.sv
rv_core_asserts.sv
tb_rv_core.sv

//--- rv_core.sv
module rv_core import rv_pkg::*; (
    input  logic    clock,
    input  logic    rst_n,
    output wb_req_t bus_req,
    input  word_t   bus_rdata,
    input  logic    bus_ack,
    output logic    commit_valid,
    output commit_t commit
);

    word_t     pc;
    word_t     inst;
    word_t     next_pc;
    word_t     result;
    word_t     rs1_data;
    word_t     rs2_data;
    reg_addr_t rd_addr;
    logic      exec;
    logic      wen;
    logic      rf_we;
    dec_t      dec;

    rv_ifu ifu_inst (
        .clock    (clock),
        .rst_n    (rst_n),
        .bus_req  (bus_req),
        .bus_rdata(bus_rdata),
        .bus_ack  (bus_ack),
        .next_pc  (next_pc),
        .pc       (pc),
        .inst     (inst),
        .exec     (exec)
    );

    rv_idu idu_inst (
        .inst(inst),
        .dec (dec)
    );

    rv_regfile regfile_inst (
        .clock   (clock),
        .rst_n   (rst_n),
        .rs1_addr(dec.rs1),
        .rs2_addr(dec.rs2),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .we      (rf_we),
        .rd_addr (rd_addr),
        .rd_data (result)
    );

    rv_exu exu_inst (
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .pc              (pc),
        .dec             (dec),
        .result          (result),
        .rd_addr_out     (rd_addr),
        .reg_write_en_out(wen),
        .next_pc         (next_pc)
    );

    assign rf_we        = wen && exec; // Write on the edge ending EXEC
    assign commit_valid = exec;
    assign commit       = '{pc: pc, rd: rd_addr, wen: wen, result: result, next_pc: next_pc};

endmodule

//--- rv_core_asserts.sv
module rv_core_asserts import rv_pkg::*; (
    input logic    clock,
    input logic    rst_n,
    input wb_req_t bus_req,
    input logic    bus_ack,
    input logic    commit_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;

    stb_implies_cyc: assert property (@(posedge clock) disable iff (!rst_n)
        bus_req.stb |-> bus_req.cyc)
    else begin
        $error("stb high without cyc");
        fail_count++;
    end

    req_held_until_ack: assert property (@(posedge clock) disable iff (!rst_n)
        bus_req.stb && !bus_ack |=> bus_req.stb && $stable(bus_req.adr))
    else begin
        $error("fetch request changed before ack");
        fail_count++;
    end

    commit_after_ack: assert property (@(posedge clock) disable iff (!rst_n)
        bus_req.stb && bus_ack |=> commit_valid)
    else begin
        $error("no commit in the cycle after ack");
        fail_count++;
    end

    commit_single_cycle: assert property (@(posedge clock) disable iff (!rst_n)
        commit_valid |=> !commit_valid)
    else begin
        $error("commit_valid high for more than one cycle");
        fail_count++;
    end

    no_fetch_during_commit: assert property (@(posedge clock) disable iff (!rst_n)
        !(bus_req.cyc && commit_valid))
    else begin
        $error("cyc and commit_valid high together");
        fail_count++;
    end

    quiet_in_reset: assert property (@(posedge clock)
        !rst_n |-> !bus_req.cyc && !commit_valid)
    else begin
        $error("bus or commit active during reset");
        fail_count++;
    end

endmodule

bind rv_core rv_core_asserts rv_core_asserts_inst (
    .clock       (clock),
    .rst_n       (rst_n),
    .bus_req     (bus_req),
    .bus_ack     (bus_ack),
    .commit_valid(commit_valid)
);

//--- rv_exu.sv
module rv_exu import rv_pkg::*; (
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    input  word_t     pc,
    input  dec_t      dec,
    output word_t     result,
    output reg_addr_t rd_addr_out,
    output logic      reg_write_en_out,
    output word_t     next_pc
);

    word_t              op_a;
    word_t              op_b;
    word_t              alu_out;
    logic [4:0]         shamt;
    logic signed [63:0] mul_full;
    logic               div_zero;
    logic               div_ovf;
    logic               branch_taken;
    word_t              pc_plus4;
    word_t              pc_imm;
    word_t              jalr_target;
    word_t              branch_next;

    rv_mux_key #(.NR_KEY(3), .KEY_LEN($bits(opcode_t)), .DATA_LEN($bits(word_t))) op_a_sel (
        .out        (op_a),
        .key        (dec.opcode),
        .default_out(rs1_data),
        .lut        ({OP_AUIPC, pc, OP_LUI, 32'b0, OP_JAL, pc})
    );

    rv_mux_key #(.NR_KEY(2), .KEY_LEN($bits(opcode_t)), .DATA_LEN($bits(word_t))) op_b_sel (
        .out        (op_b),
        .key        (dec.opcode),
        .default_out(dec.imm),
        .lut        ({OP_REG, rs2_data, OP_BRANCH, rs2_data})
    );

    assign shamt    = (dec.opcode == OP_IMM) ? dec.imm[4:0] : rs2_data[4:0];
    assign mul_full = $signed(op_a) * $signed(op_b); // Sign extended to 64 bits
    assign div_zero = (op_b == '0);
    assign div_ovf  = (op_a == INT_MIN) && (op_b == '1);

    always_comb begin
        alu_out = '0;
        if (!dec.inst_invalid) begin
            case (dec.opcode)
                OP_LUI, OP_AUIPC, OP_JAL, OP_LOAD, OP_STORE: begin
                    alu_out = op_a + op_b; // JAL target and load/store address
                end
                OP_IMM: begin
                    case ({dec.funct7, dec.funct3})
                        {F7_BASE, 3'b001}: alu_out = op_a << shamt;
                        {F7_BASE, 3'b101}: alu_out = op_a >> shamt;
                        {F7_ALT, 3'b101}:  alu_out = $signed(op_a) >>> shamt;
                        default: begin
                            case (dec.funct3)
                                3'b000:  alu_out = op_a + op_b;
                                3'b010:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
                                3'b011:  alu_out = {31'b0, op_a < op_b};
                                3'b100:  alu_out = op_a ^ op_b;
                                3'b110:  alu_out = op_a | op_b;
                                3'b111:  alu_out = op_a & op_b;
                                default: alu_out = '0; // Bad shift encoding
                            endcase
                        end
                    endcase
                end
                OP_REG: begin
                    case ({dec.funct7, dec.funct3})
                        {F7_BASE, 3'b000}:   alu_out = op_a + op_b;
                        {F7_ALT, 3'b000}:    alu_out = op_a - op_b;
                        {F7_BASE, 3'b001}:   alu_out = op_a << shamt;
                        {F7_BASE, 3'b010}:   alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
                        {F7_BASE, 3'b011}:   alu_out = {31'b0, op_a < op_b};
                        {F7_BASE, 3'b100}:   alu_out = op_a ^ op_b;
                        {F7_BASE, 3'b101}:   alu_out = op_a >> shamt;
                        {F7_ALT, 3'b101}:    alu_out = $signed(op_a) >>> shamt;
                        {F7_BASE, 3'b110}:   alu_out = op_a | op_b;
                        {F7_BASE, 3'b111}:   alu_out = op_a & op_b;
                        {F7_MULDIV, 3'b000}: alu_out = mul_full[31:0];
                        {F7_MULDIV, 3'b001}: alu_out = mul_full[63:32];
                        {F7_MULDIV, 3'b100}: begin
                            if (div_zero)     alu_out = '1;
                            else if (div_ovf) alu_out = INT_MIN;
                            else              alu_out = $signed(op_a) / $signed(op_b);
                        end
                        {F7_MULDIV, 3'b101}: alu_out = div_zero ? '1 : op_a / op_b;
                        {F7_MULDIV, 3'b110}: begin
                            if (div_zero)     alu_out = op_a;
                            else if (div_ovf) alu_out = '0;
                            else              alu_out = $signed(op_a) % $signed(op_b);
                        end
                        {F7_MULDIV, 3'b111}: alu_out = div_zero ? op_a : op_a % op_b;
                        default:             alu_out = '0;
                    endcase
                end
                default: alu_out = '0;
            endcase
        end
    end

    always_comb begin
        case (dec.funct3)
            3'b000:  branch_taken = (op_a == op_b);
            3'b001:  branch_taken = (op_a != op_b);
            3'b100:  branch_taken = $signed(op_a) < $signed(op_b);
            3'b101:  branch_taken = $signed(op_a) >= $signed(op_b);
            3'b110:  branch_taken = op_a < op_b;
            3'b111:  branch_taken = op_a >= op_b;
            default: branch_taken = 1'b0;
        endcase
    end

    assign pc_plus4    = pc + 32'd4;
    assign pc_imm      = pc + dec.imm; // Taken branch
    assign jalr_target = (rs1_data + dec.imm) & ~32'd1;
    assign branch_next = branch_taken ? pc_imm : pc_plus4;

    rv_mux_key #(.NR_KEY(2), .KEY_LEN($bits(opcode_t)), .DATA_LEN($bits(word_t))) result_sel (
        .out        (result),
        .key        (dec.opcode),
        .default_out(alu_out),
        .lut        ({OP_JAL, pc_plus4, OP_JALR, pc_plus4})
    );

    rv_mux_key #(.NR_KEY(3), .KEY_LEN($bits(opcode_t)), .DATA_LEN($bits(word_t))) next_pc_sel (
        .out        (next_pc),
        .key        (dec.opcode),
        .default_out(pc_plus4),
        .lut        ({OP_JAL, alu_out, OP_JALR, jalr_target, OP_BRANCH, branch_next})
    );

    assign rd_addr_out      = dec.rd;
    assign reg_write_en_out = dec.reg_write && !dec.inst_invalid;

endmodule

//--- rv_idu.sv
module rv_idu import rv_pkg::*; (
    input  word_t inst,
    output dec_t  dec
);

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec        = '0;
        dec.opcode = inst[6:0];
        dec.rd     = inst[11:7];
        dec.funct3 = inst[14:12];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];
        dec.funct7 = inst[31:25];
        case (inst[6:0])
            OP_LUI, OP_AUIPC: begin
                dec.imm       = imm_u;
                dec.reg_write = 1'b1;
            end
            OP_JAL: begin
                dec.imm       = imm_j;
                dec.reg_write = 1'b1;
            end
            OP_JALR, OP_IMM: begin
                dec.imm       = imm_i;
                dec.reg_write = 1'b1;
            end
            OP_BRANCH: begin
                dec.imm = imm_b;
            end
            OP_STORE: begin
                dec.imm = imm_s;
            end
            OP_LOAD, OP_FENCE, OP_SYSTEM: begin
                dec.imm = imm_i; // No register write
            end
            OP_REG: begin
                dec.reg_write    = 1'b1;
                dec.inst_invalid = !(inst[31:25] inside {F7_BASE, F7_ALT, F7_MULDIV});
            end
            default: begin
                dec.inst_invalid = 1'b1;
            end
        endcase
    end

endmodule

//--- rv_ifu.sv
module rv_ifu import rv_pkg::*; (
    input  logic    clock,
    input  logic    rst_n,
    output wb_req_t bus_req,
    input  word_t   bus_rdata,
    input  logic    bus_ack,
    input  word_t   next_pc,
    output word_t   pc,
    output word_t   inst,
    output logic    exec
);

    fetch_state_t state;
    fetch_state_t state_next;
    logic         fetching;

    assign fetching = (state == FETCH);
    assign exec     = (state == EXEC);

    // Address and strobe held stable until ack
    assign bus_req = '{cyc: fetching, stb: fetching, adr: pc};

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                state_next = FETCH;
            end
            FETCH: begin
                if (bus_ack) begin
                    state_next = EXEC;
                end
            end
            EXEC: begin
                state_next = FETCH;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            pc    <= RESET_PC;
        end else begin
            state <= state_next;
            if (exec) begin
                pc <= next_pc; // Retire edge
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fetching && bus_ack) begin
            inst <= bus_rdata; // Data valid in ack cycle
        end
    end

endmodule

//--- rv_mux_key.sv
module rv_mux_key #(
    parameter int NR_KEY   = 2,
    parameter int KEY_LEN  = 1,
    parameter int DATA_LEN = 1
) (
    output logic [DATA_LEN-1:0]                  out,
    input  logic [KEY_LEN-1:0]                   key,
    input  logic [DATA_LEN-1:0]                  default_out,
    input  logic [NR_KEY*(KEY_LEN+DATA_LEN)-1:0] lut
);

    // Each pair is {key, data} with data in the low bits
    always_comb begin
        out = default_out;
        for (int i = 0; i < NR_KEY; i++) begin
            if (lut[i*(KEY_LEN+DATA_LEN)+DATA_LEN +: KEY_LEN] == key) begin
                out = lut[i*(KEY_LEN+DATA_LEN) +: DATA_LEN];
            end
        end
    end

endmodule

//--- rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_FENCE  = 7'b0001111;
    localparam opcode_t OP_SYSTEM = 7'b1110011;

    localparam funct7_t F7_BASE   = 7'b0000000;
    localparam funct7_t F7_ALT    = 7'b0100000; // SUB, SRA, SRAI
    localparam funct7_t F7_MULDIV = 7'b0000001;

    localparam word_t RESET_PC = 32'h8000_0000;
    localparam word_t INT_MIN  = 32'h8000_0000;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        EXEC
    } fetch_state_t;

    typedef struct packed {
        logic  cyc;
        logic  stb;
        word_t adr;
    } wb_req_t;

    typedef struct packed {
        opcode_t   opcode;
        funct3_t   funct3;
        funct7_t   funct7;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
        logic      reg_write;
        logic      inst_invalid;
    } dec_t;

    typedef struct packed {
        word_t     pc;
        reg_addr_t rd;
        logic      wen;
        word_t     result;
        word_t     next_pc;
    } commit_t;

endpackage

//--- rv_regfile.sv
module rv_regfile import rv_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      we,
    input  reg_addr_t rd_addr,
    input  word_t     rd_data
);

    word_t regs [32];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd_addr != '0)) begin
            regs[rd_addr] <= rd_data; // x0 never written
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- tb_rv_core.sv
module tb_rv_core import rv_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_INSTR    = 2000;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int TIMEOUT_NS   = NUM_INSTR * 6 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;
    localparam int REQ_WAIT_MAX = 8;

    // OP encodings as {funct7, funct3} with the M extension from index 10
    localparam logic [9:0] REG_OPS [16] = '{
        {F7_BASE, 3'b000}, {F7_BASE, 3'b001}, {F7_BASE, 3'b010}, {F7_BASE, 3'b011},
        {F7_BASE, 3'b100}, {F7_BASE, 3'b101}, {F7_BASE, 3'b110}, {F7_BASE, 3'b111},
        {F7_ALT, 3'b000}, {F7_ALT, 3'b101},
        {F7_MULDIV, 3'b000}, {F7_MULDIV, 3'b001}, {F7_MULDIV, 3'b100},
        {F7_MULDIV, 3'b101}, {F7_MULDIV, 3'b110}, {F7_MULDIV, 3'b111}
    };
    localparam funct3_t BRANCH_F3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    localparam opcode_t BAD_OPS [3]   = '{7'b0000000, 7'b1111111, 7'b0101011};

    logic    clock;
    logic    rst_n;
    wb_req_t bus_req;
    word_t   bus_rdata;
    logic    bus_ack;
    logic    commit_valid;
    commit_t commit;

    word_t   rng_state = 32'd84500;
    word_t   model_regs [32];
    word_t   model_pc;
    commit_t expected_q [$];
    word_t   pending_q [$];
    int      value_errors = 0;
    int      other_errors = 0;
    int      assert_errors = 0;

    rv_core rv_core_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .bus_req     (bus_req),
        .bus_rdata   (bus_rdata),
        .bus_ack     (bus_ack),
        .commit_valid(commit_valid),
        .commit      (commit)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    function automatic word_t xorshift32();
        word_t x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic word_t next_instr();
        word_t sel;
        word_t rnd;
        word_t iw;
        int    idx;
        if (pending_q.size() != 0) begin
            return pending_q.pop_front();
        end
        sel = xorshift32() % 100;
        rnd = xorshift32();
        iw  = xorshift32();
        iw[11:10] = 2'b00; // Registers x0..x7 only
        iw[19:18] = 2'b00;
        iw[24:23] = 2'b00;
        if (sel < 20) begin
            iw[6:0] = OP_IMM;
            if (iw[14:12] == 3'b001) begin
                iw[31:25] = F7_BASE;
            end else if (iw[14:12] == 3'b101) begin
                iw[31:25] = rnd[0] ? F7_ALT : F7_BASE;
            end
        end else if (sel < 40) begin
            iw[6:0] = OP_REG;
            idx = rnd % 16;
            {iw[31:25], iw[14:12]} = REG_OPS[idx];
            if (idx >= 10 && rnd[8:7] == 2'b00) begin
                iw[24:20] = 5'd0; // Zero divisor
            end
            if (rnd[12:9] == 4'b0000) begin
                iw[31:25] = 7'b0000010; // Undefined funct7
            end
        end else if (sel < 45) begin
            iw[6:0] = OP_LUI;
        end else if (sel < 50) begin
            iw[6:0] = OP_AUIPC;
        end else if (sel < 60) begin
            iw[6:0]   = OP_BRANCH;
            iw[14:12] = BRANCH_F3[rnd % 6];
        end else if (sel < 65) begin
            iw[6:0] = OP_JAL;
        end else if (sel < 70) begin
            iw[6:0]   = OP_JALR;
            iw[14:12] = 3'b000;
        end else if (sel < 75) begin
            iw[6:0] = OP_LOAD;
        end else if (sel < 80) begin
            iw[6:0] = OP_STORE;
        end else if (sel < 84) begin
            iw[6:0] = OP_SYSTEM;
        end else if (sel < 88) begin
            iw[6:0] = BAD_OPS[rnd % 3];
        end else if (sel < 96) begin
            // Seed a register with INT_MIN or all ones
            if (rnd[0]) begin
                iw = {20'h80000, iw[11:7], OP_LUI};
            end else begin
                iw = {12'hfff, 5'd0, 3'b000, iw[11:7], OP_IMM};
            end
        end else begin
            // INT_MIN / -1 for DIV and REM
            iw = {20'h80000, 5'd5, OP_LUI};
            pending_q.push_back({12'hfff, 5'd0, 3'b000, 5'd6, OP_IMM});
            pending_q.push_back({F7_MULDIV, 5'd6, 5'd5, 3'b100, 5'd7, OP_REG});
            pending_q.push_back({F7_MULDIV, 5'd6, 5'd5, 3'b110, 5'd4, OP_REG});
        end
        return iw;
    endfunction

    function automatic word_t reg_alu(funct7_t f7, funct3_t f3, word_t a, word_t b);
        logic signed [63:0] prod;
        prod = $signed(a) * $signed(b);
        case ({f7, f3})
            {F7_BASE, 3'b000}: return a + b;
            {F7_ALT, 3'b000}:  return a - b;
            {F7_BASE, 3'b001}: return a << b[4:0];
            {F7_BASE, 3'b010}: return {31'b0, $signed(a) < $signed(b)};
            {F7_BASE, 3'b011}: return {31'b0, a < b};
            {F7_BASE, 3'b100}: return a ^ b;
            {F7_BASE, 3'b101}: return a >> b[4:0];
            {F7_ALT, 3'b101}:  return $signed(a) >>> b[4:0];
            {F7_BASE, 3'b110}: return a | b;
            {F7_BASE, 3'b111}: return a & b;
            {F7_MULDIV, 3'b000}: return prod[31:0];
            {F7_MULDIV, 3'b001}: return prod[63:32];
            {F7_MULDIV, 3'b100}: begin
                if (b == '0) return '1;
                if (a == INT_MIN && b == '1) return INT_MIN;
                return $signed(a) / $signed(b);
            end
            {F7_MULDIV, 3'b101}: begin
                if (b == '0) return '1;
                return a / b;
            end
            {F7_MULDIV, 3'b110}: begin
                if (b == '0) return a;
                if (a == INT_MIN && b == '1) return '0;
                return $signed(a) % $signed(b);
            end
            {F7_MULDIV, 3'b111}: begin
                if (b == '0) return a;
                return a % b;
            end
            default: return '0;
        endcase
    endfunction

    function automatic logic branch_holds(funct3_t f3, word_t a, word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic commit_t model_exec(word_t iw);
        commit_t c;
        funct3_t f3;
        funct7_t f7;
        word_t   a;
        word_t   b;
        word_t   imm_i;
        word_t   imm_s;
        word_t   imm_b;
        word_t   imm_j;
        f3    = iw[14:12];
        f7    = iw[31:25];
        a     = model_regs[iw[19:15]];
        b     = model_regs[iw[24:20]];
        imm_i = {{20{iw[31]}}, iw[31:20]};
        imm_s = {{20{iw[31]}}, iw[31:25], iw[11:7]};
        imm_b = {{20{iw[31]}}, iw[7], iw[30:25], iw[11:8], 1'b0};
        imm_j = {{12{iw[31]}}, iw[19:12], iw[20], iw[30:21], 1'b0};
        c = '{pc: model_pc, rd: iw[11:7], wen: 1'b0, result: '0, next_pc: model_pc + 32'd4};
        case (iw[6:0])
            OP_LUI:   c.result = {iw[31:12], 12'b0};
            OP_AUIPC: c.result = model_pc + {iw[31:12], 12'b0};
            OP_JAL: begin
                c.result  = model_pc + 32'd4;
                c.next_pc = model_pc + imm_j;
            end
            OP_JALR: begin
                c.result  = model_pc + 32'd4;
                c.next_pc = (a + imm_i) & ~32'd1;
            end
            OP_BRANCH: begin
                if (branch_holds(f3, a, b)) begin
                    c.next_pc = model_pc + imm_b;
                end
            end
            OP_LOAD:  c.result = a + imm_i;
            OP_STORE: c.result = a + imm_s;
            OP_IMM: begin
                // Only shifts carry a real funct7
                c.result = reg_alu((f3 == 3'b001 || f3 == 3'b101) ? f7 : F7_BASE, f3, a, imm_i);
            end
            OP_REG: begin
                if (f7 inside {F7_BASE, F7_ALT, F7_MULDIV}) begin
                    c.result = reg_alu(f7, f3, a, b);
                end
            end
            default: c.result = '0;
        endcase
        c.wen = iw[6:0] inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_IMM} ||
                (iw[6:0] == OP_REG && f7 inside {F7_BASE, F7_ALT, F7_MULDIV});
        return c;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %08h actual %08h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %0d actual %0d", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic compare_commit(input commit_t exp);
        check_word("commit.pc", exp.pc, commit.pc);
        check_reg("commit.rd", exp.rd, commit.rd);
        check_bit("commit.wen", exp.wen, commit.wen);
        check_word("commit.result", exp.result, commit.result);
        check_word("commit.next_pc", exp.next_pc, commit.next_pc);
    endtask

    // Commit monitor
    always @(negedge clock) begin
        if (rst_n && commit_valid) begin
            if (expected_q.size() == 0) begin
                $display("Error at %0t: commit without a fetched instruction", $time);
                other_errors++;
            end else begin
                compare_commit(expected_q.pop_front());
            end
        end
    end

    initial begin
        word_t   iw;
        commit_t exp;
        int      wait_cycles;
        logic    stalled;
        clock     = 1'b0;
        rst_n     = 1'b0;
        bus_rdata = '0;
        bus_ack   = 1'b0;
        stalled   = 1'b0;
        model_pc  = RESET_PC;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        for (int n = 0; n < NUM_INSTR && !stalled; n++) begin
            wait_cycles = 0;
            @(negedge clock);
            while (!(bus_req.cyc && bus_req.stb) && !stalled) begin
                if (wait_cycles == REQ_WAIT_MAX) begin
                    $display("Error at %0t: the DUT issued no fetch request", $time);
                    other_errors++;
                    stalled = 1'b1;
                end else begin
                    wait_cycles++;
                    @(negedge clock);
                end
            end
            if (!stalled) begin
                repeat (xorshift32() % 4) @(negedge clock); // Slave wait states
                check_word("bus_req.adr", model_pc, bus_req.adr);
                iw  = next_instr();
                exp = model_exec(iw);
                expected_q.push_back(exp);
                if (exp.wen && exp.rd != '0) begin
                    model_regs[exp.rd] = exp.result;
                end
                model_pc  = exp.next_pc;
                bus_rdata = iw;
                bus_ack   = 1'b1;
                @(negedge clock);
                bus_ack   = 1'b0;
                bus_rdata = xorshift32();
                if (!commit_valid) begin
                    $display("Error at %0t: no commit in the cycle after ack", $time);
                    other_errors++;
                end
            end
        end
        @(negedge clock);
        @(negedge clock);
        if (expected_q.size() != 0) begin
            $display("Error: %0d fetched instructions never committed", expected_q.size());
            other_errors++;
        end
        assert_errors = rv_core_inst.rv_core_asserts_inst.fail_count;
        $display("Errors: %0d value, %0d sequence, %0d assertion",
                 value_errors, other_errors, assert_errors);
        if (value_errors + other_errors + assert_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Error: run did not finish within %0d ns", TIMEOUT_NS);
        $display("Something failed");
        $finish;
    end

endmodule
